//--- Bender.yml
package:
  name: uart_axil_bridge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_bridge_pkg.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/frame_parser.sv
      - verilog/axil_master.sv
      - verilog/frame_builder.sv
      - verilog/bridge_stats.sv
      - verilog/uart_axil_bridge.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/uart_axil_bridge_assert.sv
      - testbench/tb_uart_axil_bridge.sv

//--- all.f
+incdir+verilog
verilog/uart_bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/frame_parser.sv
verilog/axil_master.sv
verilog/frame_builder.sv
verilog/bridge_stats.sv
verilog/uart_axil_bridge.sv
testbench/uart_axil_bridge_assert.sv
testbench/tb_uart_axil_bridge.sv

//--- testbench/tb_uart_axil_bridge.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module tb_uart_axil_bridge;

    localparam int  CLKS   = `BRIDGE_CLKS_PER_BIT;
    localparam real CLK_NS = 100.0;
    localparam int  N_ROWS = 8;

    typedef struct packed {
        uart_bridge_pkg::byte_t   cmd;
        uart_bridge_pkg::addr_t   addr;
        uart_bridge_pkg::word_t   data;
        logic                     corrupt;      // Send an inverted checksum
        uart_bridge_pkg::status_t exp_status;
        uart_bridge_pkg::word_t   exp_rdata;
    } row_t;

    logic                       clk;
    logic                       rst;
    logic                       uart_rx;
    logic                       uart_tx;
    logic                       clear_stats;
    uart_bridge_pkg::axil_m2s_t axil_m2s;
    uart_bridge_pkg::axil_s2m_t axil_s2m;
    uart_bridge_pkg::count_t    write_count;
    uart_bridge_pkg::count_t    read_count;
    uart_bridge_pkg::status_t   last_status;
    logic                       busy;

    row_t                       rows [N_ROWS];
    string                      names [N_ROWS] = '{"write_word", "read_back", "bad_checksum",
        "read_unchanged", "unknown_cmd", "read_slverr", "read_timeout", "write_slverr"};
    uart_bridge_pkg::word_t     mem [16];
    uart_bridge_pkg::axil_m2s_t slv_m2s;       // Master outputs at the last edge
    uart_bridge_pkg::axil_s2m_t slv_prev;      // What the slave drove before that edge

    uart_axil_bridge uart_axil_bridge_i (
        .clk(clk), .rst(rst), .uart_rx(uart_rx), .uart_tx(uart_tx),
        .axil_m2s(axil_m2s), .axil_s2m(axil_s2m), .clear_stats(clear_stats),
        .write_count(write_count), .read_count(read_count),
        .last_status(last_status), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic uart_bridge_pkg::word_t fill_word(input logic [3:0] idx);
        return {4'hF, idx, 4'hE, idx, 4'hD, idx, 4'hC, idx};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                                        what, expected, actual));
        end
    endtask

    // -----------------------------------------------------------------------
    // Serial driver, called 1 ns after a rising edge
    // -----------------------------------------------------------------------
    task automatic send_byte(input uart_bridge_pkg::byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};                 // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            uart_rx = bits[i];
            repeat (CLKS) @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame(input row_t row);
        uart_bridge_pkg::byte_t chk;
        chk = row.cmd;
        send_byte(`BRIDGE_SOF_REQ);
        send_byte(row.cmd);
        for (int i = 3; i >= 0; i--) begin
            send_byte(row.addr[8*i +: 8]);
            chk ^= row.addr[8*i +: 8];
        end
        if (row.cmd == `BRIDGE_CMD_WRITE) begin
            for (int i = 3; i >= 0; i--) begin
                send_byte(row.data[8*i +: 8]);
                chk ^= row.data[8*i +: 8];
            end
        end
        send_byte(row.corrupt ? ~chk : chk);
    endtask

    // Serial receiver, samples near mid-bit on falling clock edges
    task automatic receive_byte(output uart_bridge_pkg::byte_t b);
        @(negedge uart_tx);
        repeat (CLKS / 2) @(negedge clk);
        assert (uart_tx === 1'b0) else stop_with_failure("Start bit on uart_tx was a glitch");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS) @(negedge clk);
        assert (uart_tx === 1'b1) else stop_with_failure("Stop bit on uart_tx was low");
    endtask

    task automatic check_response(input string name, input row_t row);
        uart_bridge_pkg::byte_t expected [$];
        uart_bridge_pkg::byte_t got;
        expected = '{`BRIDGE_SOF_RSP, row.exp_status, row.cmd};
        if (row.cmd == `BRIDGE_CMD_READ && row.exp_status == `BRIDGE_ST_OK) begin
            for (int i = 3; i >= 0; i--) expected.push_back(row.exp_rdata[8*i +: 8]);
        end
        foreach (expected[k]) begin
            receive_byte(got);
            check_value($sformatf("%s byte %0d", name, k), expected[k], got);
            // Transmitter still in its stop bit
            check_value($sformatf("%s busy", name), 1, busy);
        end
    endtask

    // -----------------------------------------------------------------------
    // AXI4-Lite slave, bit 30 answers SLVERR and bit 31 never answers
    // -----------------------------------------------------------------------
    always @(posedge clk) begin
        slv_m2s  = axil_m2s;
        slv_prev = axil_s2m;
        #1;
        if (rst) begin
            axil_s2m = '0;
        end else begin
            if (slv_prev.awready && slv_m2s.awvalid) begin
                axil_s2m.awready = 1'b0;
                axil_s2m.wready  = 1'b0;
                axil_s2m.bvalid  = 1'b1;
                axil_s2m.bresp   = slv_m2s.awaddr[30] ? 2'b10 : 2'b00;
                if (!slv_m2s.awaddr[30]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (slv_m2s.wstrb[b]) begin     // Byte lanes per wstrb
                            mem[slv_m2s.awaddr[5:2]][8*b +: 8] = slv_m2s.wdata[8*b +: 8];
                        end
                    end
                end
            end else if (slv_m2s.awvalid && slv_m2s.wvalid && !slv_prev.bvalid
                         && !slv_m2s.awaddr[31]) begin
                axil_s2m.awready = 1'b1;
                axil_s2m.wready  = 1'b1;
            end
            if (slv_prev.bvalid && slv_m2s.bready) axil_s2m.bvalid = 1'b0;
            if (slv_prev.arready && slv_m2s.arvalid) begin
                axil_s2m.arready = 1'b0;
                axil_s2m.rvalid  = 1'b1;
                axil_s2m.rresp   = slv_m2s.araddr[30] ? 2'b10 : 2'b00;
                axil_s2m.rdata   = slv_m2s.araddr[30] ? '0 : mem[slv_m2s.araddr[5:2]];
            end else if (slv_m2s.arvalid && !slv_prev.rvalid && !slv_m2s.araddr[31]) begin
                axil_s2m.arready = 1'b1;
            end
            if (slv_prev.rvalid && slv_m2s.rready) axil_s2m.rvalid = 1'b0;
        end
    end

    // Watchdog, 40 byte times per table row plus reset
    initial begin
        #((N_ROWS * 40 * 10 * CLKS + 40) * CLK_NS);
        stop_with_failure("Watchdog expired before the test sequence finished");
    end

    initial begin
        int n_write;
        int n_read;
        uart_rx     = 1'b1;
        clear_stats = 1'b0;
        rst         = 1'b1;
        axil_s2m    = '0;
        n_write     = 0;
        n_read      = 0;
        for (int i = 0; i < 16; i++) mem[i] = fill_word(4'(i));
        rows[0] = '{8'h01, 32'h0000_0010, 32'h1234_5678, 1'b0, 8'h00, 32'h0000_0000};
        rows[1] = '{8'h81, 32'h0000_0010, 32'h0000_0000, 1'b0, 8'h00, 32'h1234_5678};
        rows[2] = '{8'h01, 32'h0000_0008, 32'hDEAD_BEEF, 1'b1, 8'h01, 32'h0000_0000};
        rows[3] = '{8'h81, 32'h0000_0008, 32'h0000_0000, 1'b0, 8'h00, 32'hF2E2_D2C2};
        rows[4] = '{8'h42, 32'h0000_000C, 32'h0000_0000, 1'b0, 8'h02, 32'h0000_0000};
        rows[5] = '{8'h81, 32'h4000_0004, 32'h0000_0000, 1'b0, 8'h03, 32'h0000_0000};
        rows[6] = '{8'h81, 32'h8000_0004, 32'h0000_0000, 1'b0, 8'h04, 32'h0000_0000};
        rows[7] = '{8'h01, 32'h4000_003C, 32'hCAFE_F00D, 1'b0, 8'h03, 32'h0000_0000};
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("busy after reset", 0, busy);

        for (int r = 0; r < N_ROWS; r++) begin
            repeat (CLKS) @(posedge clk);       // Idle line between frames
            #1;
            fork
                send_frame(rows[r]);
                check_response(names[r], rows[r]);
            join
            if (rows[r].cmd == `BRIDGE_CMD_WRITE) n_write++;
            if (rows[r].cmd == `BRIDGE_CMD_READ) n_read++;
        end

        while (busy) @(posedge clk);
        #1;
        check_value("write_count", n_write, write_count);
        check_value("read_count", n_read, read_count);
        check_value("last_status", rows[N_ROWS-1].exp_status, last_status);

        clear_stats = 1'b1;
        @(posedge clk);
        #1;
        clear_stats = 1'b0;
        @(posedge clk);
        #1;
        check_value("write_count after clear", 0, write_count);
        check_value("read_count after clear", 0, read_count);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- testbench/uart_axil_bridge_assert.sv
`timescale 1ns/1ps

module uart_axil_bridge_assert (
    input logic                         clk,
    input logic                         rst,
    input uart_bridge_pkg::axil_m2s_t   axil_m2s,
    input uart_bridge_pkg::axil_s2m_t   axil_s2m,
    input uart_bridge_pkg::bridge_rsp_t rsp,
    input logic                         rsp_valid,
    input logic                         rsp_ready,
    input logic                         timed_out     // Master may abandon the access here
);

    // -----------------------------------------------------------------------
    // Address channels hold until ready unless the timeout hits
    // -----------------------------------------------------------------------
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        axil_m2s.awvalid && !axil_s2m.awready && !timed_out
        |=> axil_m2s.awvalid && $stable(axil_m2s.awaddr))
        else $error("awvalid or awaddr changed before awready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        axil_m2s.arvalid && !axil_s2m.arready && !timed_out
        |=> axil_m2s.arvalid && $stable(axil_m2s.araddr))
        else $error("arvalid or araddr changed before arready");

    reset_idle: assert property (@(posedge clk)
        rst |=> !axil_m2s.awvalid && !axil_m2s.wvalid && !axil_m2s.arvalid && !rsp_valid)
        else $error("AXI or response valid high during reset");

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp_valid dropped or rsp changed before rsp_ready");

endmodule

bind axil_master uart_axil_bridge_assert axil_master_assert_i (
    .clk(clk), .rst(rst), .axil_m2s(axil_m2s), .axil_s2m(axil_s2m), .rsp(rsp),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .timed_out(timed_out)
);

//--- verilog/axil_master.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module axil_master (
    input  logic                         clk,
    input  logic                         rst,
    input  uart_bridge_pkg::bridge_req_t req,
    input  logic                         req_valid,
    output logic                         req_ready,
    output uart_bridge_pkg::bridge_rsp_t rsp,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output uart_bridge_pkg::axil_m2s_t   axil_m2s,
    input  uart_bridge_pkg::axil_s2m_t   axil_s2m
);

    localparam int TW = $clog2(`BRIDGE_AXI_TIMEOUT);

    uart_bridge_pkg::axil_state_t state;
    logic [TW-1:0] timer;
    logic          timed_out;
    logic          done;

    assign req_ready = (state == uart_bridge_pkg::AX_IDLE) && !rsp_valid;
    assign timed_out = (timer == TW'(`BRIDGE_AXI_TIMEOUT - 1));
    assign done      = (state == uart_bridge_pkg::AX_WRITE && axil_s2m.bvalid) ||
                       (state == uart_bridge_pkg::AX_READ_DATA && axil_s2m.rvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= uart_bridge_pkg::AX_IDLE;
            rsp_valid        <= 1'b0;
            axil_m2s.awvalid <= 1'b0;
            axil_m2s.wvalid  <= 1'b0;
            axil_m2s.bready  <= 1'b0;
            axil_m2s.arvalid <= 1'b0;
            axil_m2s.rready  <= 1'b0;
        end else begin
            timer <= timer + 1'b1;
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            case (state)
                uart_bridge_pkg::AX_IDLE: begin
                    timer <= '0;
                    if (req_valid && req_ready) begin
                        rsp.cmd         <= req.cmd;
                        rsp.status      <= req.status;
                        rsp.rdata       <= '0;
                        axil_m2s.awaddr <= req.addr;
                        axil_m2s.araddr <= req.addr;
                        axil_m2s.wdata  <= req.wdata;
                        axil_m2s.wstrb  <= 4'hF;
                        if (req.status != `BRIDGE_ST_OK) begin
                            rsp_valid <= 1'b1;              // Parser error, no AXI access
                        end else if (req.cmd == `BRIDGE_CMD_WRITE) begin
                            axil_m2s.awvalid <= 1'b1;
                            axil_m2s.wvalid  <= 1'b1;
                            axil_m2s.bready  <= 1'b1;
                            state            <= uart_bridge_pkg::AX_WRITE;
                        end else begin
                            axil_m2s.arvalid <= 1'b1;
                            state            <= uart_bridge_pkg::AX_READ_ADDR;
                        end
                    end
                end
                uart_bridge_pkg::AX_WRITE: begin
                    if (axil_s2m.awready) axil_m2s.awvalid <= 1'b0;
                    if (axil_s2m.wready)  axil_m2s.wvalid  <= 1'b0;
                    if (axil_s2m.bvalid) begin
                        axil_m2s.bready <= 1'b0;
                        if (axil_s2m.bresp != 2'b00) rsp.status <= `BRIDGE_ST_AXI;
                        rsp_valid <= 1'b1;
                        state     <= uart_bridge_pkg::AX_IDLE;
                    end
                end
                uart_bridge_pkg::AX_READ_ADDR: begin
                    if (axil_s2m.arready) begin
                        axil_m2s.arvalid <= 1'b0;
                        axil_m2s.rready  <= 1'b1;
                        state            <= uart_bridge_pkg::AX_READ_DATA;
                    end
                end
                default: begin
                    if (axil_s2m.rvalid) begin
                        axil_m2s.rready <= 1'b0;
                        rsp.rdata       <= axil_s2m.rdata;
                        if (axil_s2m.rresp != 2'b00) rsp.status <= `BRIDGE_ST_AXI;
                        rsp_valid <= 1'b1;
                        state     <= uart_bridge_pkg::AX_IDLE;
                    end
                end
            endcase

            // -------------------------------------------------------------------
            // Timeout, a completing handshake in the same cycle wins
            // -------------------------------------------------------------------
            if (state != uart_bridge_pkg::AX_IDLE && timed_out && !done) begin
                axil_m2s.awvalid <= 1'b0;
                axil_m2s.wvalid  <= 1'b0;
                axil_m2s.bready  <= 1'b0;
                axil_m2s.arvalid <= 1'b0;
                axil_m2s.rready  <= 1'b0;
                rsp.status       <= `BRIDGE_ST_TIMEOUT;
                rsp.rdata        <= '0;
                rsp_valid        <= 1'b1;
                state            <= uart_bridge_pkg::AX_IDLE;
            end
        end
    end

endmodule

//--- verilog/bridge_stats.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module bridge_stats (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear_stats,
    input  logic                     rsp_fire,
    input  uart_bridge_pkg::byte_t   rsp_cmd,
    input  uart_bridge_pkg::status_t rsp_status,
    input  logic                     stage_busy,
    output uart_bridge_pkg::count_t  write_count,
    output uart_bridge_pkg::count_t  read_count,
    output uart_bridge_pkg::status_t last_status,
    output logic                     busy
);

    always_ff @(posedge clk) begin
        if (rst) begin
            write_count <= '0;
            read_count  <= '0;
            last_status <= '0;
            busy        <= 1'b0;
        end else begin
            busy <= stage_busy;
            if (rsp_fire) last_status <= rsp_status;
            if (clear_stats) begin
                write_count <= '0;                      // Clear beats a same-cycle count
                read_count  <= '0;
            end else if (rsp_fire && rsp_cmd == `BRIDGE_CMD_WRITE) begin
                write_count <= write_count + 1'b1;
            end else if (rsp_fire && rsp_cmd == `BRIDGE_CMD_READ) begin
                read_count <= read_count + 1'b1;
            end
        end
    end

endmodule

//--- verilog/frame_builder.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module frame_builder (
    input  logic                         clk,
    input  logic                         rst,
    input  uart_bridge_pkg::bridge_rsp_t rsp,
    input  logic                         rsp_valid,
    output logic                         rsp_ready,
    output uart_bridge_pkg::byte_t       tx_data,
    output logic                         tx_valid,
    input  logic                         tx_ready
);

    uart_bridge_pkg::build_state_t state;
    uart_bridge_pkg::bridge_rsp_t  held;        // rdata shifts left as bytes go out
    logic [1:0] idx;

    assign rsp_ready = (state == uart_bridge_pkg::B_IDLE);
    assign tx_valid  = !rsp_ready;

    always_comb begin
        case (state)
            uart_bridge_pkg::B_SOF:    tx_data = `BRIDGE_SOF_RSP;
            uart_bridge_pkg::B_STATUS: tx_data = held.status;
            uart_bridge_pkg::B_CMD:    tx_data = held.cmd;
            default:                   tx_data = held.rdata[31:24];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= uart_bridge_pkg::B_IDLE;
        end else begin
            case (state)
                uart_bridge_pkg::B_IDLE: begin
                    if (rsp_valid) begin
                        held  <= rsp;
                        state <= uart_bridge_pkg::B_SOF;
                    end
                end
                uart_bridge_pkg::B_SOF: begin
                    if (tx_ready) state <= uart_bridge_pkg::B_STATUS;
                end
                uart_bridge_pkg::B_STATUS: begin
                    if (tx_ready) state <= uart_bridge_pkg::B_CMD;
                end
                uart_bridge_pkg::B_CMD: begin
                    idx <= '0;
                    // Data bytes only for a successful read
                    if (tx_ready && held.cmd == `BRIDGE_CMD_READ && held.status == `BRIDGE_ST_OK) begin
                        state <= uart_bridge_pkg::B_DATA;
                    end else if (tx_ready) begin
                        state <= uart_bridge_pkg::B_IDLE;
                    end
                end
                default: begin
                    if (tx_ready) begin
                        held.rdata <= {held.rdata[23:0], 8'h00};
                        idx        <= idx + 1'b1;
                        if (idx == 2'd3) state <= uart_bridge_pkg::B_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- verilog/frame_parser.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module frame_parser (
    input  logic                         clk,
    input  logic                         rst,
    input  uart_bridge_pkg::byte_t       rx_data,
    input  logic                         rx_valid,
    output uart_bridge_pkg::bridge_req_t req,
    output logic                         req_valid,
    input  logic                         req_ready
);

    uart_bridge_pkg::parse_state_t state;
    uart_bridge_pkg::byte_t        chk;         // Running XOR from CMD onwards
    logic [1:0] idx;                            // Byte index within ADDR or DATA
    logic       cmd_known;

    assign req_valid = (state == uart_bridge_pkg::P_HOLD);
    assign cmd_known = (req.cmd == `BRIDGE_CMD_WRITE) || (req.cmd == `BRIDGE_CMD_READ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= uart_bridge_pkg::P_SOF;
        end else if (state == uart_bridge_pkg::P_HOLD) begin
            // Bytes arriving here are lost
            if (req_ready) begin
                state <= uart_bridge_pkg::P_SOF;
            end
        end else if (rx_valid) begin
            chk <= chk ^ rx_data;
            idx <= idx + 1'b1;
            case (state)
                uart_bridge_pkg::P_SOF: begin
                    chk <= '0;
                    if (rx_data == `BRIDGE_SOF_REQ) begin
                        state <= uart_bridge_pkg::P_CMD;
                    end
                end
                uart_bridge_pkg::P_CMD: begin
                    req.cmd <= rx_data;
                    idx     <= '0;
                    state   <= uart_bridge_pkg::P_ADDR;
                end
                uart_bridge_pkg::P_ADDR: begin
                    req.addr <= {req.addr[23:0], rx_data};  // MSB first
                    if (idx == 2'd3 && req.cmd == `BRIDGE_CMD_WRITE) begin
                        state <= uart_bridge_pkg::P_DATA;
                    end else if (idx == 2'd3) begin
                        state <= uart_bridge_pkg::P_CHK;    // Reads and unknown commands
                    end
                end
                uart_bridge_pkg::P_DATA: begin
                    req.wdata <= {req.wdata[23:0], rx_data};
                    if (idx == 2'd3) begin
                        state <= uart_bridge_pkg::P_CHK;
                    end
                end
                default: begin
                    // Checksum error wins over unknown command
                    if (chk != rx_data) begin
                        req.status <= `BRIDGE_ST_CHK;
                    end else if (!cmd_known) begin
                        req.status <= `BRIDGE_ST_CMD;
                    end else begin
                        req.status <= `BRIDGE_ST_OK;
                    end
                    state <= uart_bridge_pkg::P_HOLD;
                end
            endcase
        end
    end

endmodule

//--- verilog/uart_axil_bridge.sv
`timescale 1ns/1ps

module uart_axil_bridge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_rx,
    output logic                       uart_tx,
    output uart_bridge_pkg::axil_m2s_t axil_m2s,
    input  uart_bridge_pkg::axil_s2m_t axil_s2m,
    input  logic                       clear_stats,
    output uart_bridge_pkg::count_t    write_count,
    output uart_bridge_pkg::count_t    read_count,
    output uart_bridge_pkg::status_t   last_status,
    output logic                       busy
);

    uart_bridge_pkg::byte_t       rx_data;
    logic                         rx_valid;
    uart_bridge_pkg::bridge_req_t req;
    logic                         req_valid;
    logic                         req_ready;
    uart_bridge_pkg::bridge_rsp_t rsp;
    logic                         rsp_valid;
    logic                         rsp_ready;
    uart_bridge_pkg::byte_t       tx_data;
    logic                         tx_valid;
    logic                         tx_ready;

    // -----------------------------------------------------------------------
    // Request pipeline, rx -> parser -> AXI master -> builder -> tx
    // -----------------------------------------------------------------------
    uart_rx uart_rx_i (
        .clk(clk), .rst(rst), .uart_rx(uart_rx), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    frame_parser frame_parser_i (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .req(req), .req_valid(req_valid), .req_ready(req_ready)
    );

    axil_master axil_master_i (
        .clk(clk), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .axil_m2s(axil_m2s), .axil_s2m(axil_s2m)
    );

    frame_builder frame_builder_i (
        .clk(clk), .rst(rst), .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    uart_tx uart_tx_i (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid),
        .tx_ready(tx_ready), .uart_tx(uart_tx)
    );

    // Statistics beside the pipeline, busy while any stage holds a frame
    bridge_stats bridge_stats_i (
        .clk(clk), .rst(rst), .clear_stats(clear_stats),
        .rsp_fire(rsp_valid && rsp_ready), .rsp_cmd(rsp.cmd), .rsp_status(rsp.status),
        .stage_busy(req_valid || rsp_valid || tx_valid || !tx_ready),
        .write_count(write_count), .read_count(read_count),
        .last_status(last_status), .busy(busy)
    );

endmodule

//--- verilog/uart_bridge_macros.svh
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// ---------------------------------------------------------------------------
// Timing
// ---------------------------------------------------------------------------
`define BRIDGE_CLKS_PER_BIT 16      // Clock cycles per UART bit
`define BRIDGE_AXI_TIMEOUT  64      // Cycles before an AXI access is abandoned

// Frame start bytes and commands
`define BRIDGE_SOF_REQ   8'hA5
`define BRIDGE_SOF_RSP   8'h5A
`define BRIDGE_CMD_WRITE 8'h01
`define BRIDGE_CMD_READ  8'h81

// Response status codes
`define BRIDGE_ST_OK      8'h00
`define BRIDGE_ST_CHK     8'h01     // Checksum mismatch
`define BRIDGE_ST_CMD     8'h02     // Unknown command
`define BRIDGE_ST_AXI     8'h03     // SLVERR or DECERR from the slave
`define BRIDGE_ST_TIMEOUT 8'h04

`endif

//--- verilog/uart_bridge_pkg.sv
package uart_bridge_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] count_t;
    typedef logic [7:0]  status_t;

    // Request from the parser, status already checked
    typedef struct packed {
        byte_t   cmd;
        addr_t   addr;
        word_t   wdata;
        status_t status;
    } bridge_req_t;

    typedef struct packed {
        byte_t   cmd;
        status_t status;
        word_t   rdata;
    } bridge_rsp_t;

    // -----------------------------------------------------------------------
    // AXI4-Lite, master to slave and slave to master
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic       awvalid;
        addr_t      awaddr;
        logic       wvalid;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        addr_t      araddr;
        logic       rready;
    } axil_m2s_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_s2m_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [2:0] {P_SOF, P_CMD, P_ADDR, P_DATA, P_CHK, P_HOLD} parse_state_t;
    typedef enum logic [1:0] {AX_IDLE, AX_WRITE, AX_READ_ADDR, AX_READ_DATA} axil_state_t;
    typedef enum logic [2:0] {B_IDLE, B_SOF, B_STATUS, B_CMD, B_DATA} build_state_t;

endpackage

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   uart_rx,
    output uart_bridge_pkg::byte_t rx_data,
    output logic                   rx_valid
);

    localparam int CLKS = `BRIDGE_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    uart_bridge_pkg::rx_state_t state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;     // Previous synced level, for edge detect

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= uart_bridge_pkg::RX_IDLE;
            rx_valid <= 1'b0;
            cnt      <= '0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                uart_bridge_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= uart_bridge_pkg::RX_START;
                    end
                end
                uart_bridge_pkg::RX_START: begin
                    if (cnt == CW'(CLKS / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // Line high again at mid-bit means a glitch
                        state   <= rx_sync ? uart_bridge_pkg::RX_IDLE : uart_bridge_pkg::RX_DATA;
                    end
                end
                uart_bridge_pkg::RX_DATA: begin
                    if (cnt == CW'(CLKS - 1)) begin
                        cnt     <= '0;
                        rx_data <= {rx_sync, rx_data[7:1]};     // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_bridge_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    if (cnt == CW'(CLKS - 1)) begin
                        rx_valid <= rx_sync;                    // Drop byte on framing error
                        state    <= uart_bridge_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_bridge_pkg::byte_t tx_data,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    output logic                   uart_tx
);

    localparam int CLKS = `BRIDGE_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    uart_bridge_pkg::tx_state_t state;
    uart_bridge_pkg::byte_t     shreg;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          bit_end;

    assign tx_ready = (state == uart_bridge_pkg::TX_IDLE);
    assign bit_end  = (cnt == CW'(CLKS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= uart_bridge_pkg::TX_IDLE;
            uart_tx <= 1'b1;
            cnt     <= '0;
        end else begin
            cnt <= (bit_end || tx_ready) ? '0 : cnt + 1'b1;
            case (state)
                uart_bridge_pkg::TX_IDLE: begin
                    if (tx_valid) begin
                        shreg   <= tx_data;
                        uart_tx <= 1'b0;                        // Start bit
                        state   <= uart_bridge_pkg::TX_START;
                    end
                end
                uart_bridge_pkg::TX_START: begin
                    if (bit_end) begin
                        uart_tx <= shreg[0];
                        shreg   <= {1'b0, shreg[7:1]};
                        bit_idx <= '0;
                        state   <= uart_bridge_pkg::TX_DATA;
                    end
                end
                uart_bridge_pkg::TX_DATA: begin
                    if (bit_end && bit_idx == 3'd7) begin
                        uart_tx <= 1'b1;                        // Stop bit
                        state   <= uart_bridge_pkg::TX_STOP;
                    end else if (bit_end) begin
                        uart_tx <= shreg[0];
                        shreg   <= {1'b0, shreg[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_bridge_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule
